// File: hdl/motorPkg.sv
`default_nettype none

package motorPkg;

    localparam int STEP_COUNT = 12;
    localparam int STEP_W = 4;
    localparam int PERIOD_W = 25;
    localparam int SPLIT_W = 2;
    localparam int OFFSET_B = 8;
    localparam int OFFSET_C = 4;
    localparam logic [STEP_W-1:0] STEP_IDLE = 4'hF;
    localparam int CARRIER_W = 8;
    localparam int ROUNDS_W = 32;
    localparam logic [PERIOD_W-1:0] PERIOD_RESET = 25'd1000;

    // Bus widths. Offsets above the register window are decoded as errors.
    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;
    localparam int REG_OFS_W = 4;

    // Sampled sine around the carrier midpoint, one level per step.
    localparam logic [CARRIER_W-1:0] DUTY_TABLE [STEP_COUNT] = '{
        8'd128, 8'd192, 8'd239, 8'd255, 8'd239, 8'd192,
        8'd128, 8'd64,  8'd17,  8'd1,   8'd17,  8'd64
    };

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axiResp_e;

    typedef enum logic [REG_OFS_W-1:0] {
        ADDR_CTRL   = 4'h0,
        ADDR_PERIOD = 4'h4,
        ADDR_STATUS = 4'h8,
        ADDR_ROUNDS = 4'hC
    } regAddr_e;

    typedef struct packed {
        logic                enable;
        logic [SPLIT_W-1:0]  splitMax;
        logic [PERIOD_W-1:0] period;
    } motorCfg_t;

    typedef struct packed {
        logic [STEP_W-1:0]  stepA;
        logic [STEP_W-1:0]  stepB;
        logic [STEP_W-1:0]  stepC;
        logic [SPLIT_W-1:0] splitSlot;
    } motorDrive_t;

    typedef struct packed {
        logic a;
        logic b;
        logic c;
    } phasePwm_t;

    typedef struct packed {
        logic [AXI_ADDR_W-1:0] awaddr;
        logic                  awvalid;
        logic [AXI_DATA_W-1:0] wdata;
        logic                  wvalid;
        logic                  bready;
        logic [AXI_ADDR_W-1:0] araddr;
        logic                  arvalid;
        logic                  rready;
    } axiLiteReq_t;

    typedef struct packed {
        logic                  awready;
        logic                  wready;
        axiResp_e              bresp;
        logic                  bvalid;
        logic                  arready;
        logic [AXI_DATA_W-1:0] rdata;
        axiResp_e              rresp;
        logic                  rvalid;
    } axiLiteRsp_t;

endpackage

`default_nettype wire

// File: hdl/axiLiteRegs.sv
`default_nettype none

module axiLiteRegs (
    input  wire                                clk,
    input  wire                                rst,
    input  motorPkg::axiLiteReq_t              axiReq,
    output motorPkg::axiLiteRsp_t              axiRsp,
    output motorPkg::motorCfg_t                cfg,
    input  motorPkg::motorDrive_t              drive,
    input  wire                                running,
    input  wire [motorPkg::ROUNDS_W-1:0]       rounds
);

    logic                               writeAccept;
    logic                               readAccept;
    logic                               bValid;
    motorPkg::axiResp_e                 bResp;
    logic                               rValid;
    motorPkg::axiResp_e                 rResp;
    logic [motorPkg::AXI_DATA_W-1:0]    rData;
    logic [motorPkg::AXI_DATA_W-1:0]    ctrlWord;
    logic [motorPkg::AXI_DATA_W-1:0]    periodWord;
    logic [motorPkg::AXI_DATA_W-1:0]    statusWord;
    logic [motorPkg::AXI_DATA_W-1:0]    readData;
    motorPkg::axiResp_e                 readResp;
    logic                               writeInRange;
    logic                               readInRange;

    // One write and one read may be outstanding at a time.
    assign writeAccept = axiReq.awvalid && axiReq.wvalid && !bValid;
    assign readAccept  = axiReq.arvalid && !rValid;

    assign writeInRange = axiReq.awaddr[motorPkg::AXI_ADDR_W-1:motorPkg::REG_OFS_W] == '0;
    assign readInRange  = axiReq.araddr[motorPkg::AXI_ADDR_W-1:motorPkg::REG_OFS_W] == '0;

    assign ctrlWord   = {26'd0, cfg.splitMax, 3'd0, cfg.enable};
    assign periodWord = {7'd0, cfg.period};
    assign statusWord = {23'd0, running, 2'd0, drive.splitSlot, drive.stepA};

    always_comb begin
        readData = '0;
        readResp = motorPkg::OKAY;
        if (!readInRange) begin
            readResp = motorPkg::SLVERR;
        end else begin
            case (motorPkg::regAddr_e'(axiReq.araddr[motorPkg::REG_OFS_W-1:0]))
                motorPkg::ADDR_CTRL:   readData = ctrlWord;
                motorPkg::ADDR_PERIOD: readData = periodWord;
                motorPkg::ADDR_STATUS: readData = statusWord;
                motorPkg::ADDR_ROUNDS: readData = motorPkg::AXI_DATA_W'(rounds);
                default:               readResp = motorPkg::SLVERR;
            endcase
        end
    end

    // Write channel and configuration registers.
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.enable   <= 1'b0;
            cfg.splitMax <= '0;
            cfg.period   <= motorPkg::PERIOD_RESET;
            bValid       <= 1'b0;
            bResp        <= motorPkg::OKAY;
        end else begin
            if (bValid && axiReq.bready) begin
                bValid <= 1'b0;
            end
            if (writeAccept) begin
                bValid <= 1'b1;
                bResp  <= motorPkg::OKAY;
                if (!writeInRange) begin
                    bResp <= motorPkg::SLVERR;
                end else begin
                    case (motorPkg::regAddr_e'(axiReq.awaddr[motorPkg::REG_OFS_W-1:0]))
                        motorPkg::ADDR_CTRL: begin
                            cfg.enable   <= axiReq.wdata[0];
                            cfg.splitMax <= axiReq.wdata[5:4];
                        end
                        motorPkg::ADDR_PERIOD: begin
                            cfg.period <= axiReq.wdata[motorPkg::PERIOD_W-1:0];
                        end
                        // Read-only registers take the write silently.
                        motorPkg::ADDR_STATUS, motorPkg::ADDR_ROUNDS: begin
                            bResp <= motorPkg::OKAY;
                        end
                        default: begin
                            bResp <= motorPkg::SLVERR;
                        end
                    endcase
                end
            end
        end
    end

    // Read channel.
    always_ff @(posedge clk) begin
        if (rst) begin
            rValid <= 1'b0;
            rResp  <= motorPkg::OKAY;
        end else begin
            if (rValid && axiReq.rready) begin
                rValid <= 1'b0;
            end
            if (readAccept) begin
                rValid <= 1'b1;
                rResp  <= readResp;
            end
        end
    end

    // Read data is sampled in the acceptance cycle.
    always_ff @(posedge clk) begin
        if (readAccept) begin
            rData <= readData;
        end
    end

    assign axiRsp = '{
        awready: writeAccept,
        wready:  writeAccept,
        bresp:   bResp,
        bvalid:  bValid,
        arready: readAccept,
        rdata:   rData,
        rresp:   rResp,
        rvalid:  rValid
    };

endmodule

`default_nettype wire

// File: hdl/stepGenerator.sv
`default_nettype none

module stepGenerator (
    input  wire                                clk,
    input  wire                                rst,
    input  motorPkg::motorCfg_t                cfg,
    output motorPkg::motorDrive_t              drive,
    output logic                               running,
    output logic [motorPkg::ROUNDS_W-1:0]      rounds
);

    logic                               enableQ;
    logic                               startPulse;
    logic                               lastCycle;
    logic                               slotEnd;
    logic                               stepAdvance;
    logic                               wrap;
    logic [motorPkg::PERIOD_W-1:0]      slotCnt;
    logic [motorPkg::STEP_W-1:0]        stepANext;

    // Maps a phase A step to a lagging phase, modulo twelve.
    function automatic logic [motorPkg::STEP_W-1:0] offsetStep(
        input logic [motorPkg::STEP_W-1:0] step,
        input int                          offset
    );
        logic [motorPkg::STEP_W:0] sum;
        if (step == motorPkg::STEP_IDLE) begin
            return motorPkg::STEP_IDLE;
        end
        sum = step + (motorPkg::STEP_W + 1)'(offset);
        if (sum >= (motorPkg::STEP_W + 1)'(motorPkg::STEP_COUNT)) begin
            sum = sum - (motorPkg::STEP_W + 1)'(motorPkg::STEP_COUNT);
        end
        return sum[motorPkg::STEP_W-1:0];
    endfunction

    assign startPulse  = cfg.enable && !enableQ;
    // Counter at 0 or 1 closes the slot.
    assign lastCycle   = slotCnt[motorPkg::PERIOD_W-1:1] == '0;
    assign slotEnd     = cfg.enable && !startPulse && lastCycle;
    assign stepAdvance = slotEnd && (drive.splitSlot == '0);
    assign wrap = stepAdvance && (drive.stepA == motorPkg::STEP_W'(motorPkg::STEP_COUNT - 1));
    assign running     = enableQ;

    always_comb begin
        stepANext = drive.stepA;
        if (!cfg.enable) begin
            stepANext = motorPkg::STEP_IDLE;
        end else if (startPulse) begin
            stepANext = '0;
        end else if (wrap) begin
            stepANext = '0;
        end else if (stepAdvance) begin
            stepANext = drive.stepA + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enableQ         <= 1'b0;
            slotCnt         <= '0;
            drive.stepA     <= motorPkg::STEP_IDLE;
            drive.stepB     <= motorPkg::STEP_IDLE;
            drive.stepC     <= motorPkg::STEP_IDLE;
            drive.splitSlot <= '0;
            rounds          <= '0;
        end else begin
            enableQ <= cfg.enable;

            if (!cfg.enable || startPulse || lastCycle) begin
                slotCnt <= cfg.period;
            end else begin
                slotCnt <= slotCnt - 1'b1;
            end

            if (!cfg.enable) begin
                drive.splitSlot <= '0;
            end else if (startPulse || stepAdvance) begin
                drive.splitSlot <= cfg.splitMax;
            end else if (slotEnd) begin
                drive.splitSlot <= drive.splitSlot - 1'b1;
            end

            // B and C follow the next A so all phases switch together.
            drive.stepA <= stepANext;
            drive.stepB <= offsetStep(stepANext, motorPkg::OFFSET_B);
            drive.stepC <= offsetStep(stepANext, motorPkg::OFFSET_C);

            if (!cfg.enable) begin
                rounds <= '0;
            end else if (wrap) begin
                rounds <= rounds + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/pwmModulator.sv
`default_nettype none

module pwmModulator (
    input  wire                        clk,
    input  wire                        rst,
    input  motorPkg::motorDrive_t      drive,
    input  wire                        running,
    output motorPkg::phasePwm_t        pwm
);

    logic [motorPkg::CARRIER_W-1:0] carrier;
    logic                           levelA;
    logic                           levelB;
    logic                           levelC;

    // High while the carrier sits below the duty of the given step.
    function automatic logic phaseOn(
        input logic [motorPkg::STEP_W-1:0]    step,
        input logic [motorPkg::CARRIER_W-1:0] level
    );
        if (step >= motorPkg::STEP_W'(motorPkg::STEP_COUNT)) begin
            return 1'b0;
        end
        return level < motorPkg::DUTY_TABLE[step];
    endfunction

    assign levelA = phaseOn(drive.stepA, carrier);
    assign levelB = phaseOn(drive.stepB, carrier);
    assign levelC = phaseOn(drive.stepC, carrier);

    always_ff @(posedge clk) begin
        if (rst) begin
            carrier <= '0;
            pwm     <= '0;
        end else begin
            // One carrier shared by all three phases.
            if (running) begin
                carrier <= carrier + 1'b1;
            end else begin
                carrier <= '0;
            end
            pwm.a <= levelA;
            pwm.b <= levelB;
            pwm.c <= levelC;
        end
    end

endmodule

`default_nettype wire

// File: hdl/motorCtrlTop.sv
`default_nettype none

module motorCtrlTop (
    input  wire                        clk,
    input  wire                        rst,
    input  motorPkg::axiLiteReq_t      axiReq,
    output motorPkg::axiLiteRsp_t      axiRsp,
    output motorPkg::motorDrive_t      drive,
    output motorPkg::phasePwm_t        pwm
);

    motorPkg::motorCfg_t                cfg;
    logic                               running;
    logic [motorPkg::ROUNDS_W-1:0]      rounds;

    // Host side configuration and status.
    axiLiteRegs uRegs (
        .clk     (clk),
        .rst     (rst),
        .axiReq  (axiReq),
        .axiRsp  (axiRsp),
        .cfg     (cfg),
        .drive   (drive),
        .running (running),
        .rounds  (rounds)
    );

    // Twelve-step commutation sequence.
    stepGenerator uStepGen (
        .clk     (clk),
        .rst     (rst),
        .cfg     (cfg),
        .drive   (drive),
        .running (running),
        .rounds  (rounds)
    );

    pwmModulator uPwm (
        .clk     (clk),
        .rst     (rst),
        .drive   (drive),
        .running (running),
        .pwm     (pwm)
    );

endmodule

`default_nettype wire

// File: tb/axiTasks.svh
// Compares one value with its expected value and logs a mismatch.
task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("CHECK FAILED at %0t: %s (got 0x%0h, expected 0x%0h)",
                 $time, what, actual, expected);
    end
endtask

// Write with optional bready back-pressure, called on a falling edge.
task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                        output logic [1:0] resp, input int holdCycles);
    int waited;
    int acceptCycles;
    axiReq.awaddr  = addr;
    axiReq.awvalid = 1'b1;
    axiReq.wdata   = data;
    axiReq.wvalid  = 1'b1;
    axiReq.bready  = (holdCycles == 0);
    waited = 0;
    acceptCycles = 0;
    do begin
        @(posedge clk);
        if (axiRsp.awready && axiRsp.wready) begin
            acceptCycles++;
        end
        @(negedge clk);
        waited++;
    end while (!axiRsp.bvalid && waited < 20);
    axiReq.awvalid = 1'b0;
    axiReq.wvalid  = 1'b0;
    if (!axiRsp.bvalid) begin
        errorCount++;
        $display("ERROR at %0t: write to 0x%0h never got a response", $time, addr);
    end
    checkValue(acceptCycles, 1, "awready and wready high for one cycle");
    resp = axiRsp.bresp;
    repeat (holdCycles) begin
        @(negedge clk);
        checkValue(32'(axiRsp.bvalid), 1, "bvalid holds while bready is low");
    end
    axiReq.bready = 1'b1;
    @(negedge clk);
    checkValue(32'(axiRsp.bvalid), 0, "bvalid clears after bready");
endtask

// Read with optional rready back-pressure, called on a falling edge.
task automatic axiRead(input logic [7:0] addr, output logic [31:0] value,
                       output logic [1:0] resp, input int holdCycles);
    int waited;
    int acceptCycles;
    axiReq.araddr  = addr;
    axiReq.arvalid = 1'b1;
    axiReq.rready  = (holdCycles == 0);
    waited = 0;
    acceptCycles = 0;
    do begin
        @(posedge clk);
        if (axiRsp.arready) begin
            acceptCycles++;
        end
        @(negedge clk);
        waited++;
    end while (!axiRsp.rvalid && waited < 20);
    axiReq.arvalid = 1'b0;
    if (!axiRsp.rvalid) begin
        errorCount++;
        $display("ERROR at %0t: read from 0x%0h never got a response", $time, addr);
    end
    checkValue(acceptCycles, 1, "arready high for one cycle");
    value = axiRsp.rdata;
    resp  = axiRsp.rresp;
    repeat (holdCycles) begin
        @(negedge clk);
        checkValue(32'(axiRsp.rvalid), 1, "rvalid holds while rready is low");
        checkValue(axiRsp.rdata, value, "rdata stable under back-pressure");
    end
    axiReq.rready = 1'b1;
    @(negedge clk);
    checkValue(32'(axiRsp.rvalid), 0, "rvalid clears after rready");
endtask

task automatic writeExpect(input logic [7:0] addr, input logic [31:0] data,
                           input logic [1:0] expResp, input string what);
    logic [1:0] resp;
    axiWrite(addr, data, resp, 0);
    checkValue(32'(resp), 32'(expResp), {what, " write response"});
endtask

task automatic readExpect(input logic [7:0] addr, input logic [31:0] expData,
                          input logic [1:0] expResp, input string what);
    logic [31:0] value;
    logic [1:0]  resp;
    axiRead(addr, value, resp, 0);
    checkValue(value, expData, {what, " read data"});
    checkValue(32'(resp), 32'(expResp), {what, " read response"});
endtask

// File: tb/motorCtrlTb.sv
`default_nettype none

module motorCtrlTb;

    localparam int CLK_PERIOD = 40;
    // Cycle estimates of tests 1 to 6.
    localparam int TEST_CYCLES = 100 + 150 + 1700 + 300 + 1700 + 150;
    localparam logic [7:0] CTRL_ADDR = 8'h00;
    localparam logic [7:0] PERIOD_ADDR = 8'h04;
    localparam logic [7:0] STATUS_ADDR = 8'h08;
    localparam logic [7:0] ROUNDS_ADDR = 8'h0C;
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [3:0] IDLE = 4'hF;

    logic                  clk;
    logic                  rst;
    motorPkg::axiLiteReq_t axiReq;
    motorPkg::axiLiteRsp_t axiRsp;
    motorPkg::motorDrive_t drive;
    motorPkg::phasePwm_t   pwm;

    integer      seed;
    int          errorCount;
    int          checkCount;
    int          testsRun;
    logic        checkOn;
    logic        lengthOn;
    int          refSplitMax;
    int          refPeriod;
    int          randPeriod;
    logic [3:0]  lastStepA;
    logic [1:0]  lastSplit;
    int          sinceStep;
    int          sinceSlot;
    int          stepChanges;
    int          wrapCount;
    logic [1:0]  axiRespHold;
    logic [31:0] readHold;
    int          dutyRef [12] = '{128, 192, 239, 255, 239, 192, 128, 64, 17, 1, 17, 64};

    motorCtrlTop dut (
        .clk    (clk),
        .rst    (rst),
        .axiReq (axiReq),
        .axiRsp (axiRsp),
        .drive  (drive),
        .pwm    (pwm)
    );

    `include "axiTasks.svh"

    function automatic int shiftedStep(input int step, input int offset);
        return (step + offset) % 12;
    endfunction

    function automatic int stepCycles(input int splitMax, input int period);
        return (splitMax + 1) * ((period < 1) ? 1 : period);
    endfunction

    task automatic startMotor(input int splitMax, input int period);
        writeExpect(CTRL_ADDR, 32'h0, RESP_OKAY, "disable");
        writeExpect(PERIOD_ADDR, 32'(period), RESP_OKAY, "period");
        refSplitMax = splitMax;
        refPeriod   = period;
        writeExpect(CTRL_ADDR, (32'(splitMax) << 4) | 32'h1, RESP_OKAY, "enable");
    endtask

    // Waits for step changes or 11 to 0 wraps counted by the monitor.
    task automatic waitEvents(input bit wraps, input int count, input int maxCycles);
        int target;
        int waited;
        @(posedge clk);
        target = (wraps ? wrapCount : stepChanges) + count;
        waited = 0;
        while ((wraps ? wrapCount : stepChanges) < target && waited < maxCycles) begin
            @(posedge clk);
            waited++;
        end
        if ((wraps ? wrapCount : stepChanges) < target) begin
            errorCount++;
            $display("ERROR at %0t: the step sequence stopped advancing", $time);
        end
        @(negedge clk);
    endtask

    // Counts high cycles over one carrier period inside the next step.
    task automatic measurePwm();
        logic [3:0] startA;
        logic [3:0] step;
        int         highA;
        int         highB;
        int         highC;
        int         waited;
        startA = drive.stepA;
        waited = 0;
        while (drive.stepA == startA && waited < 1000) begin
            @(negedge clk);
            waited++;
        end
        if (drive.stepA == startA) begin
            errorCount++;
            $display("ERROR at %0t: no step change seen for the PWM window", $time);
        end
        step  = drive.stepA;
        highA = 0;
        highB = 0;
        highC = 0;
        repeat (256) begin
            @(negedge clk);
            highA += int'(pwm.a);
            highB += int'(pwm.b);
            highC += int'(pwm.c);
            checkValue(32'(drive.stepA), 32'(step), "step held across PWM window");
        end
        checkValue(highA, dutyRef[step], "phase A duty");
        checkValue(highB, dutyRef[shiftedStep(step, 8)], "phase B duty");
        checkValue(highC, dutyRef[shiftedStep(step, 4)], "phase C duty");
    endtask

    task automatic reportTest(input int num, input string name);
        testsRun++;
        $display("Test %0d (%s) done, %0d errors so far", num, name, errorCount);
    endtask

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Drive monitor: phase offsets, step order, step and slot lengths.
    always @(negedge clk) begin
        if (checkOn) begin
            sinceStep++;
            sinceSlot++;
            if (drive.stepA != IDLE) begin
                checkValue(32'(drive.stepB), shiftedStep(drive.stepA, 8), "stepB from stepA");
                checkValue(32'(drive.stepC), shiftedStep(drive.stepA, 4), "stepC from stepA");
                if (drive.stepA != lastStepA || drive.splitSlot != lastSplit) begin
                    if (lengthOn && lastStepA != IDLE) begin
                        checkValue(sinceSlot, stepCycles(0, refPeriod), "slot length");
                    end
                    sinceSlot = 0;
                end
                if (drive.stepA != lastStepA) begin
                    if (lastStepA == IDLE) begin
                        checkValue(32'(drive.stepA), 0, "first step after enable");
                    end else begin
                        checkValue(32'(drive.stepA), shiftedStep(lastStepA, 1), "step order");
                        if (lengthOn) begin
                            checkValue(sinceStep, stepCycles(refSplitMax, refPeriod),
                                       "step length");
                        end
                        if (lastStepA == 4'd11) begin
                            wrapCount++;
                        end
                    end
                    checkValue(32'(drive.splitSlot), refSplitMax, "split slot reload");
                    sinceStep = 0;
                    stepChanges++;
                end else if (drive.splitSlot != lastSplit) begin
                    checkValue(32'(drive.splitSlot), 32'(lastSplit) - 1, "split countdown");
                end
            end
            lastStepA = drive.stepA;
            lastSplit = drive.splitSlot;
        end
    end

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("Timeout: the run did not end within %0d cycles", TEST_CYCLES * 2);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        axiReq = '0;
        seed = 32'h230b;
        errorCount = 0;
        checkCount = 0;
        testsRun = 0;
        checkOn = 1'b0;
        lengthOn = 1'b0;
        refSplitMax = 0;
        refPeriod = 0;
        lastStepA = IDLE;
        lastSplit = 2'd0;
        sinceStep = 0;
        sinceSlot = 0;
        stepChanges = 0;
        wrapCount = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkOn = 1'b1;

        readExpect(CTRL_ADDR, 32'h0, RESP_OKAY, "CTRL after reset");
        readExpect(PERIOD_ADDR, 32'd1000, RESP_OKAY, "PERIOD after reset");
        readExpect(STATUS_ADDR, 32'h00F, RESP_OKAY, "STATUS after reset");
        readExpect(ROUNDS_ADDR, 32'h0, RESP_OKAY, "ROUNDS after reset");
        writeExpect(CTRL_ADDR, 32'hFFFF_FFF0, RESP_OKAY, "CTRL");
        readExpect(CTRL_ADDR, 32'h30, RESP_OKAY, "CTRL");
        writeExpect(PERIOD_ADDR, 32'hFFFF_FFFF, RESP_OKAY, "PERIOD");
        readExpect(PERIOD_ADDR, 32'h01FF_FFFF, RESP_OKAY, "PERIOD");
        writeExpect(STATUS_ADDR, 32'h123, RESP_OKAY, "STATUS");
        readExpect(STATUS_ADDR, 32'h00F, RESP_OKAY, "STATUS after write");
        writeExpect(ROUNDS_ADDR, 32'h5, RESP_OKAY, "ROUNDS");
        readExpect(ROUNDS_ADDR, 32'h0, RESP_OKAY, "ROUNDS after write");
        reportTest(1, "reset and registers");

        startMotor(0, 2);
        waitEvents(1'b0, 14, 100);
        writeExpect(CTRL_ADDR, 32'h0, RESP_OKAY, "disable");
        reportTest(2, "phase relation and order");

        lengthOn = 1'b1;
        for (int sm = 0; sm < 4; sm++) begin
            randPeriod = 1 + int'($unsigned($random(seed)) % 40);
            startMotor(sm, randPeriod);
            waitEvents(1'b0, 4, 5 * stepCycles(sm, randPeriod) + 40);
        end
        lengthOn = 1'b0;
        writeExpect(CTRL_ADDR, 32'h0, RESP_OKAY, "disable");
        reportTest(3, "step length");

        wrapCount = 0;
        startMotor(0, 5);
        waitEvents(1'b1, 2, 200);
        readExpect(ROUNDS_ADDR, 32'd2, RESP_OKAY, "ROUNDS after two wraps");
        writeExpect(CTRL_ADDR, 32'h0, RESP_OKAY, "disable");
        checkValue(32'(drive.stepA), 32'(IDLE), "stepA idle after disable");
        checkValue(32'(drive.stepB), 32'(IDLE), "stepB idle after disable");
        checkValue(32'(drive.stepC), 32'(IDLE), "stepC idle after disable");
        readExpect(ROUNDS_ADDR, 32'h0, RESP_OKAY, "ROUNDS after disable");
        repeat (16) begin
            @(negedge clk);
            checkValue(32'(pwm), 32'h0, "pwm low while disabled");
        end
        reportTest(4, "revolutions and disable");

        startMotor(0, 400);
        repeat (3) measurePwm();
        writeExpect(CTRL_ADDR, 32'h0, RESP_OKAY, "disable");
        reportTest(5, "PWM duty");

        readExpect(8'h10, 32'h0, RESP_SLVERR, "offset 0x10");
        writeExpect(8'h14, 32'hDEAD, RESP_SLVERR, "offset 0x14");
        readExpect(8'hFC, 32'h0, RESP_SLVERR, "offset 0xFC");
        readExpect(8'h02, 32'h0, RESP_SLVERR, "unmapped offset 0x02");
        axiWrite(CTRL_ADDR, 32'h20, axiRespHold, 4);
        checkValue(32'(axiRespHold), 32'(RESP_OKAY), "write response under back-pressure");
        axiRead(CTRL_ADDR, readHold, axiRespHold, 5);
        checkValue(readHold, 32'h20, "CTRL read under back-pressure");
        checkValue(32'(axiRespHold), 32'(RESP_OKAY), "read response under back-pressure");
        readExpect(PERIOD_ADDR, 32'd400, RESP_OKAY, "PERIOD after back-pressure");
        reportTest(6, "bus errors and back-pressure");

        $display("Summary: %0d tests, %0d checks, %0d errors", testsRun, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: motorCtrl.f
hdl/motorPkg.sv
hdl/axiLiteRegs.sv
hdl/stepGenerator.sv
hdl/pwmModulator.sv
hdl/motorCtrlTop.sv
tb/motorCtrlTb.sv
+incdir+tb

// File: build.sh
#!/usr/bin/env bash
# Compile and run the motor controller testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_TEXT="Finished with errors"

verilator --binary --timing -Wno-fatal --top-module motorCtrlTb -f motorCtrl.f -o motorCtrlSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/motorCtrlSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "$FAIL_TEXT" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation passed"
exit 0
